// File: pong_consts.svh
/* Pong field geometry and game constants
   Screen positions count from the start of the sync pulse */
`ifndef PONG_CONSTS_SVH
`define PONG_CONSTS_SVH

`default_nettype none

// 640x480 timing, only the parts that place the field
`define PONG_H              640 // Visible width
`define PONG_HS             96  // H sync width
`define PONG_HBP            48  // H back porch
`define PONG_V              480 // Visible height
`define PONG_VS             2   // V sync height
`define PONG_VBP            33  // V back porch

// Game objects
`define PONG_BORDER         8   // Top and bottom border height
`define PONG_BALL_SIZE      16  // Ball is square
`define PONG_BALL_SPEED     4   // Pixels per frame in x and y
`define PONG_PADDLE_H       64
`define PONG_PADDLE_W       16
`define PONG_PADDLE_SPEED   4   // Pixels per frame

// Joystick word bit positions
`define PONG_JOY_UP         3
`define PONG_JOY_DOWN       2
`define PONG_JOY_FIRE       4

`define PONG_POINT_FRAMES   8   // Pause after a point, in frames

// Field origin and start positions
`define PONG_X0             (`PONG_HS + `PONG_HBP)
`define PONG_Y0             (`PONG_VS + `PONG_VBP)
`define PONG_BALL_X_MID     (`PONG_X0 + (`PONG_H - `PONG_BALL_SIZE) / 2)
`define PONG_BALL_Y_MID     (`PONG_Y0 + (`PONG_V - `PONG_BALL_SIZE) / 2)
`define PONG_PADDLE_Y_MID   (`PONG_Y0 + (`PONG_V - `PONG_PADDLE_H) / 2)

`default_nettype wire

`endif

// File: pong_pkg.sv
/* Pong shared types
   Coordinates, scores, joystick words and the rally state */
`default_nettype none

package pong_pkg;

	// Screen coordinate, sync pulse included
	typedef logic [9:0] coord_t;

	// Player score, wraps after 15
	typedef logic [3:0] score_t;

	// Joystick word from the IO side
	// Bit 3 up, bit 2 down, bit 4 fire
	typedef logic [7:0] joy_t;

	// Rally control
	typedef enum logic [1:0] {
		ST_IDLE,  // Ball centred, waiting for fire
		ST_PLAY,  // Ball moving
		ST_POINT  // Point pause
	} game_state_t;

endpackage

`default_nettype wire

// File: field_if.sv
/* Playfield positions shared between the game blocks
   Ball and paddle coordinates, one driver each */
`default_nettype none

interface field_if import pong_pkg::*; ();

	coord_t ball_x;     // Ball left edge
	coord_t ball_y;     // Ball top edge
	coord_t paddle_0_y; // Left paddle top edge
	coord_t paddle_1_y; // Right paddle top edge

	// Ball logic needs both paddles for its hit tests
	modport ball_mp (
		output ball_x,
		output ball_y,
		input  paddle_0_y,
		input  paddle_1_y
	);

	modport paddle0_mp (output paddle_0_y);
	modport paddle1_mp (output paddle_1_y);

	// Observers only
	modport view_mp (
		input ball_x,
		input ball_y,
		input paddle_0_y,
		input paddle_1_y
	);

endinterface

`default_nettype wire

// File: paddle_ctrl.sv
/* One player's paddle
   Moves with joystick up and down, stops at the borders */
`include "pong_consts.svh"
`default_nettype none

module paddle_ctrl import pong_pkg::*; #(
	parameter int PLAYER = 0 // 0 left, 1 right
) (
	input  logic VGA_VS,
	input  logic rst_n,
	input  joy_t joy,
	field_if     pos       // paddle0_mp or paddle1_mp
);

	localparam coord_t TOP_LIM = coord_t'(`PONG_Y0 + `PONG_BORDER);
	localparam coord_t BOT_LIM = coord_t'(`PONG_Y0 + `PONG_V - `PONG_BORDER - `PONG_PADDLE_H);
	localparam coord_t STEP    = coord_t'(`PONG_PADDLE_SPEED);

	coord_t pos_q; // Paddle top edge

	// Down has priority when both bits are set
	always_ff @(posedge VGA_VS) begin
		if (!rst_n) begin
			pos_q <= coord_t'(`PONG_PADDLE_Y_MID);
		end else if (joy[`PONG_JOY_DOWN] && (pos_q < BOT_LIM)) begin
			pos_q <= pos_q + STEP;
		end else if (joy[`PONG_JOY_UP] && (pos_q > TOP_LIM)) begin
			pos_q <= pos_q - STEP;
		end
	end

	// Only the modport's own signal is touched
	generate
		if (PLAYER == 0) begin : g_left
			assign pos.paddle_0_y = pos_q;
		end else begin : g_right
			assign pos.paddle_1_y = pos_q;
		end
	endgenerate

endmodule

`default_nettype wire

// File: ball_motion.sv
/* Ball position and direction
   Steps the ball each frame, bounces off borders and paddles, flags exits */
`include "pong_consts.svh"
`default_nettype none

module ball_motion import pong_pkg::*; (
	input  logic VGA_VS,
	input  logic rst_n,
	input  logic game_running,
	field_if.ball_mp field,
	output logic exit_left,
	output logic exit_right
);

	// Hit windows and thresholds, all on the ball's top left corner
	localparam coord_t LEFT_HIT   = coord_t'(`PONG_X0 + `PONG_PADDLE_W);
	localparam coord_t RIGHT_HIT  = coord_t'(`PONG_X0 + `PONG_H - `PONG_PADDLE_W - `PONG_BALL_SIZE);
	localparam coord_t LEFT_EXIT  = coord_t'(`PONG_X0);
	localparam coord_t RIGHT_EXIT = coord_t'(`PONG_X0 + `PONG_H - `PONG_BALL_SIZE);
	localparam coord_t TOP_LIM    = coord_t'(`PONG_Y0 + `PONG_BORDER);
	localparam coord_t BOT_LIM    = coord_t'(`PONG_Y0 + `PONG_V - `PONG_BORDER - `PONG_BALL_SIZE);
	localparam coord_t BALL_SZ    = coord_t'(`PONG_BALL_SIZE);
	localparam coord_t PAD_H      = coord_t'(`PONG_PADDLE_H);
	localparam coord_t STEP       = coord_t'(`PONG_BALL_SPEED);

	coord_t ball_x_q;
	coord_t ball_y_q;
	logic   move_x_q; // 1 moves right
	logic   move_y_q; // 1 moves down
	logic   hit_0;
	logic   hit_1;

	// Ball overlaps the left paddle column and its vertical span
	assign hit_0 = (ball_x_q < LEFT_HIT) &&
	               (ball_y_q > field.paddle_0_y - BALL_SZ) &&
	               (ball_y_q < field.paddle_0_y + PAD_H);

	// Same for the right paddle
	assign hit_1 = (ball_x_q > RIGHT_HIT) &&
	               (ball_y_q > field.paddle_1_y - BALL_SZ) &&
	               (ball_y_q < field.paddle_1_y + PAD_H);

	assign exit_left  = (ball_x_q <= LEFT_EXIT);
	assign exit_right = (ball_x_q >= RIGHT_EXIT);

	// Direction flags follow the old position, later tests win
	always_ff @(posedge VGA_VS) begin
		if (!rst_n) begin
			move_x_q <= 1'b1;
			move_y_q <= 1'b1;
		end else begin
			if (hit_0 || exit_left)  move_x_q <= 1'b1; // Bounce to the right
			if (hit_1 || exit_right) move_x_q <= 1'b0; // Bounce to the left
			if (ball_y_q < TOP_LIM)  move_y_q <= 1'b1; // Off the top border
			if (ball_y_q >= BOT_LIM) move_y_q <= 1'b0; // Off the bottom border
		end
	end

	// Step while the rally runs, otherwise park in the centre
	always_ff @(posedge VGA_VS) begin
		if (!rst_n || !game_running) begin
			ball_x_q <= coord_t'(`PONG_BALL_X_MID);
			ball_y_q <= coord_t'(`PONG_BALL_Y_MID);
		end else begin
			ball_x_q <= move_x_q ? ball_x_q + STEP : ball_x_q - STEP;
			ball_y_q <= move_y_q ? ball_y_q + STEP : ball_y_q - STEP;
		end
	end

	assign field.ball_x = ball_x_q;
	assign field.ball_y = ball_y_q;

endmodule

`default_nettype wire

// File: game_fsm.sv
/* Rally control FSM
   Idle, play and point pause; keeps both player scores */
`include "pong_consts.svh"
`default_nettype none

module game_fsm import pong_pkg::*; (
	input  logic   VGA_VS,
	input  logic   rst_n,
	input  joy_t   joystick_0,
	input  joy_t   joystick_1,
	input  logic   exit_left,
	input  logic   exit_right,
	input  logic   timer_done,
	output logic   game_running,
	output logic   timer_start,
	output score_t score_0,
	output score_t score_1
);

	game_state_t state_q;
	game_state_t state_d;
	logic        fire;
	logic        ball_out;

	assign fire     = joystick_0[`PONG_JOY_FIRE] | joystick_1[`PONG_JOY_FIRE];
	assign ball_out = exit_left | exit_right;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:  if (fire) state_d = ST_PLAY;
			ST_PLAY:  if (ball_out) state_d = ST_POINT;
			ST_POINT: if (timer_done) state_d = ST_IDLE; // Fire ignored here
			default:  state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge VGA_VS) begin
		if (!rst_n) state_q <= ST_IDLE;
		else        state_q <= state_d;
	end

	// Points go to the player on the far side of the exit
	always_ff @(posedge VGA_VS) begin
		if (!rst_n) begin
			score_0 <= '0;
			score_1 <= '0;
		end else if (state_q == ST_PLAY) begin
			if (exit_left)  score_1 <= score_1 + score_t'(1);
			if (exit_right) score_0 <= score_0 + score_t'(1);
		end
	end

	assign game_running = (state_q == ST_PLAY);

	// High for the single frame that ends the rally
	assign timer_start = (state_q == ST_PLAY) && ball_out;

endmodule

`default_nettype wire

// File: point_timer.sv
/* Point pause timer
   Counts frames after a start and pulses done once the pause is over */
`include "pong_consts.svh"
`default_nettype none

module point_timer (
	input  logic VGA_VS,
	input  logic rst_n,
	input  logic timer_start,
	output logic timer_done
);

	localparam int CNT_W = $clog2(`PONG_POINT_FRAMES);
	localparam logic [CNT_W-1:0] LOAD = CNT_W'(`PONG_POINT_FRAMES - 1);

	logic [CNT_W-1:0] cnt_q; // Frames left, 0 when idle
	logic             done_q;

	// Loaded at the start edge, so done lands on the last pause frame
	always_ff @(posedge VGA_VS) begin
		if (!rst_n) begin
			cnt_q  <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0; // Pulse, one frame wide
			if (timer_start) begin
				cnt_q <= LOAD;
			end else if (cnt_q != '0) begin
				cnt_q  <= cnt_q - 1'b1;
				done_q <= (cnt_q == CNT_W'(1));
			end
		end
	end

	assign timer_done = done_q;

endmodule

`default_nettype wire

// File: pong_core.sv
/* Pong game core, clocked once per frame by vertical sync
   Paddles, ball, rally FSM and point timer */
`default_nettype none

module pong_core import pong_pkg::*; (
	input  logic   VGA_VS,
	input  logic   rst_n,
	input  joy_t   joystick_0,
	input  joy_t   joystick_1,
	output coord_t ball_x,
	output coord_t ball_y,
	output coord_t paddle_0_y,
	output coord_t paddle_1_y,
	output logic   game_running,
	output score_t score_0,
	output score_t score_1
);

	field_if fld ();

	logic exit_left;
	logic exit_right;
	logic timer_start;
	logic timer_done;

	// Left paddle
	paddle_ctrl #(.PLAYER(0)) paddle0 (
		.VGA_VS (VGA_VS),
		.rst_n  (rst_n),
		.joy    (joystick_0),
		.pos    (fld.paddle0_mp)
	);

	// Right paddle
	paddle_ctrl #(.PLAYER(1)) paddle1 (
		.VGA_VS (VGA_VS),
		.rst_n  (rst_n),
		.joy    (joystick_1),
		.pos    (fld.paddle1_mp)
	);

	ball_motion ball (
		.VGA_VS       (VGA_VS),
		.rst_n        (rst_n),
		.game_running (game_running),
		.field        (fld.ball_mp),
		.exit_left    (exit_left),
		.exit_right   (exit_right)
	);

	game_fsm fsm (
		.VGA_VS       (VGA_VS),
		.rst_n        (rst_n),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.exit_left    (exit_left),
		.exit_right   (exit_right),
		.timer_done   (timer_done),
		.game_running (game_running),
		.timer_start  (timer_start),
		.score_0      (score_0),
		.score_1      (score_1)
	);

	point_timer timer (
		.VGA_VS      (VGA_VS),
		.rst_n       (rst_n),
		.timer_start (timer_start),
		.timer_done  (timer_done)
	);

	// Positions out as plain ports
	assign ball_x     = fld.ball_x;
	assign ball_y     = fld.ball_y;
	assign paddle_0_y = fld.paddle_0_y;
	assign paddle_1_y = fld.paddle_1_y;

endmodule

`default_nettype wire

// File: pong_assert.sv
/* Pong core properties, bound to the core
   Score steps, paddle limits and the parked ball */
`include "pong_consts.svh"
`default_nettype none

module pong_assert import pong_pkg::*; (
	input logic   VGA_VS,
	input logic   rst_n,
	input coord_t ball_x,
	input coord_t ball_y,
	input coord_t paddle_0_y,
	input coord_t paddle_1_y,
	input logic   game_running,
	input score_t score_0,
	input score_t score_1
);

	localparam coord_t TOP_LIM = coord_t'(`PONG_Y0 + `PONG_BORDER);
	localparam coord_t BOT_LIM = coord_t'(`PONG_Y0 + `PONG_V - `PONG_BORDER - `PONG_PADDLE_H);
	localparam coord_t MID_X   = coord_t'(`PONG_BALL_X_MID);
	localparam coord_t MID_Y   = coord_t'(`PONG_BALL_Y_MID);

	// A score only ever moves up by one
	a_score_0: assert property (@(posedge VGA_VS) disable iff (!rst_n)
		$changed(score_0) |-> score_0 == score_t'($past(score_0) + 1'b1))
		else $error("score_0 jumped");
	a_score_1: assert property (@(posedge VGA_VS) disable iff (!rst_n)
		$changed(score_1) |-> score_1 == score_t'($past(score_1) + 1'b1))
		else $error("score_1 jumped");

	a_paddles: assert property (@(posedge VGA_VS) disable iff (!rst_n)
		paddle_0_y >= TOP_LIM && paddle_0_y <= BOT_LIM &&
		paddle_1_y >= TOP_LIM && paddle_1_y <= BOT_LIM)
		else $error("paddle out of range");

	// One frame after a stopped frame the ball sits in the centre
	a_parked: assert property (@(posedge VGA_VS) disable iff (!rst_n)
		!game_running |=> (ball_x == MID_X && ball_y == MID_Y))
		else $error("ball not centred");

endmodule

bind pong_core pong_assert asrt0 (
	.VGA_VS       (VGA_VS),
	.rst_n        (rst_n),
	.ball_x       (ball_x),
	.ball_y       (ball_y),
	.paddle_0_y   (paddle_0_y),
	.paddle_1_y   (paddle_1_y),
	.game_running (game_running),
	.score_0      (score_0),
	.score_1      (score_1)
);

`default_nettype wire

// File: pong_tb.sv
/* Pong core testbench
   Table driven rows and random rallies checked against a frame-rule model */
`include "pong_consts.svh"
`default_nettype none

module pong_tb import pong_pkg::*; ();

	localparam int PAD_TOP  = `PONG_Y0 + `PONG_BORDER;                            // 43
	localparam int PAD_BOT  = `PONG_Y0 + `PONG_V - `PONG_BORDER - `PONG_PADDLE_H; // 443
	localparam int BALL_TOP = `PONG_Y0 + `PONG_BORDER;
	localparam int BALL_BOT = `PONG_Y0 + `PONG_V - `PONG_BORDER - `PONG_BALL_SIZE;
	localparam int X_LEFT   = `PONG_X0;
	localparam int X_RIGHT  = `PONG_X0 + `PONG_H - `PONG_BALL_SIZE;
	localparam int NROWS    = 13;

	logic   VGA_VS;
	logic   rst_n;
	joy_t   joystick_0;
	joy_t   joystick_1;
	coord_t ball_x;
	coord_t ball_y;
	coord_t paddle_0_y;
	coord_t paddle_1_y;
	logic   game_running;
	score_t score_0;
	score_t score_1;

	int errors   = 0;
	int timeouts = 0;
	int seed     = 32'h2b652eed;
	logic checking = 1'b0;

	// Each row holds joy0 joy1 frames paddle_0_y paddle_1_y score_0 score_1
	int rows [0:NROWS-1][0:6] = '{
		'{8'h00, 8'h00,   4, 243, 243, 0, 0}, // Idle after reset
		'{8'h08, 8'h04,  60,  43, 443, 0, 0}, // Both clamp
		'{8'h04, 8'h08,  25, 143, 343, 0, 0},
		'{8'h10, 8'h00,   1, 143, 343, 0, 0}, // Fire starts rally 1
		'{8'h00, 8'h00,  82, 143, 343, 1, 0}, // Right exit leaves the core in the pause
		'{8'h00, 8'h10,   4, 143, 343, 1, 0}, // Fire during pause
		'{8'h00, 8'h00,   3, 143, 343, 1, 0},
		'{8'h08, 8'h00,  15,  83, 343, 1, 0}, // Left paddle into the ball's path
		'{8'h00, 8'h10,   1,  83, 343, 1, 0}, // Rally 2
		'{8'h00, 8'h00, 240,  83, 343, 2, 0}, // Left bounce and then a right exit
		'{8'h04, 8'h00,  90, 443, 343, 2, 0}, // Left paddle out of the way
		'{8'h10, 8'h00,   1, 443, 343, 2, 0}, // Rally 3
		'{8'h00, 8'h00,  90, 443, 343, 2, 1}  // Left exit
	};

	// Reference model state
	int   m_p0, m_p1;       // Paddle top edges
	int   m_bx, m_by;       // Ball top left corner
	int   m_mx, m_my;       // Direction flags where 1 is right or down
	int   m_st, m_s0, m_s1; // FSM state and scores
	int   m_pc;             // Frames spent in the point pause
	logic ex_l, ex_r;       // Exit tests on the old position
	logic h0, h1;           // Paddle hits
	logic b_top, b_bot;     // Border tests on the old position

	pong_core dut0 (
		.VGA_VS       (VGA_VS),
		.rst_n        (rst_n),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.ball_x       (ball_x),
		.ball_y       (ball_y),
		.paddle_0_y   (paddle_0_y),
		.paddle_1_y   (paddle_1_y),
		.game_running (game_running),
		.score_0      (score_0),
		.score_1      (score_1)
	);

	always #5 VGA_VS = ~VGA_VS;

	task automatic check_val(input string name, input int got, input int exp);
		assert (got == exp) else begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// Polls on the falling edge so the FSM state is settled
	task automatic wait_state(input game_state_t st, input int limit);
		int n;
		n = 0;
		while (dut0.fsm.state_q != st && n < limit) begin
			@(negedge VGA_VS);
			n++;
		end
		if (dut0.fsm.state_q != st) begin
			timeouts++;
			$display("Timed out at %0t waiting for FSM state %s", $time, st.name());
		end
	endtask

	// Frame rules evaluated on the old inputs and old positions
	always @(posedge VGA_VS) begin
		if (!rst_n) begin
			m_p0 = `PONG_PADDLE_Y_MID;
			m_p1 = `PONG_PADDLE_Y_MID;
			m_bx = `PONG_BALL_X_MID;
			m_by = `PONG_BALL_Y_MID;
			m_mx = 1;
			m_my = 1;
			m_st = 0; // 0 idle, 1 play, 2 point
			m_s0 = 0;
			m_s1 = 0;
			m_pc = 0;
		end else begin
			ex_l = (m_bx <= X_LEFT);
			ex_r = (m_bx >= X_RIGHT);
			b_top = (m_by < BALL_TOP);
			b_bot = (m_by >= BALL_BOT);
			h0 = (m_bx < X_LEFT + `PONG_PADDLE_W) && (m_by + `PONG_BALL_SIZE > m_p0) &&
			     (m_by < m_p0 + `PONG_PADDLE_H);
			h1 = (m_bx > X_RIGHT - `PONG_PADDLE_W) && (m_by + `PONG_BALL_SIZE > m_p1) &&
			     (m_by < m_p1 + `PONG_PADDLE_H);
			if (m_st == 1) begin
				m_bx = m_mx ? m_bx + `PONG_BALL_SPEED : m_bx - `PONG_BALL_SPEED;
				m_by = m_my ? m_by + `PONG_BALL_SPEED : m_by - `PONG_BALL_SPEED;
			end else begin
				m_bx = `PONG_BALL_X_MID; // Parked while not playing
				m_by = `PONG_BALL_Y_MID;
			end
			if (h0 || ex_l) m_mx = 1;
			if (h1 || ex_r) m_mx = 0;
			if (b_top) m_my = 1;
			if (b_bot) m_my = 0;
			if (joystick_0[`PONG_JOY_DOWN] && m_p0 < PAD_BOT) m_p0 += `PONG_PADDLE_SPEED;
			else if (joystick_0[`PONG_JOY_UP] && m_p0 > PAD_TOP) m_p0 -= `PONG_PADDLE_SPEED;
			if (joystick_1[`PONG_JOY_DOWN] && m_p1 < PAD_BOT) m_p1 += `PONG_PADDLE_SPEED;
			else if (joystick_1[`PONG_JOY_UP] && m_p1 > PAD_TOP) m_p1 -= `PONG_PADDLE_SPEED;
			case (m_st)
				0: if (joystick_0[`PONG_JOY_FIRE] || joystick_1[`PONG_JOY_FIRE]) m_st = 1;
				1: if (ex_l || ex_r) begin
					if (ex_l) m_s1 = (m_s1 + 1) % 16; // Left exit scores for player 1
					if (ex_r) m_s0 = (m_s0 + 1) % 16;
					m_st = 2;
					m_pc = 0;
				end
				default: begin
					m_pc++;
					if (m_pc == `PONG_POINT_FRAMES) m_st = 0; // Pause over
				end
			endcase
		end
	end

	always @(negedge VGA_VS) begin
		if (checking) begin
			check_val("ball_x", int'(ball_x), m_bx);
			check_val("ball_y", int'(ball_y), m_by);
			check_val("paddle_0_y", int'(paddle_0_y), m_p0);
			check_val("paddle_1_y", int'(paddle_1_y), m_p1);
			check_val("game_running", int'(game_running), int'(m_st == 1));
			check_val("score_0", int'(score_0), m_s0);
			check_val("score_1", int'(score_1), m_s1);
		end
	end

	// Hard limit on the whole run
	initial begin
		#400000;
		$display("Run did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int n;
		VGA_VS = 1'b0;
		rst_n = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		repeat (16) @(posedge VGA_VS);
		rst_n <= 1'b1;
		@(negedge VGA_VS);
		check_val("paddle_0_y", int'(paddle_0_y), 243);
		check_val("paddle_1_y", int'(paddle_1_y), 243);
		check_val("ball_x", int'(ball_x), 456);
		check_val("ball_y", int'(ball_y), 267);
		check_val("game_running", int'(game_running), 0);
		check_val("score_0", int'(score_0), 0);
		check_val("score_1", int'(score_1), 0);
		@(posedge VGA_VS);
		checking = 1'b1;
		for (int i = 0; i <= NROWS; i++) begin
			joystick_0 <= (i < NROWS) ? joy_t'(rows[i][0]) : '0;
			joystick_1 <= (i < NROWS) ? joy_t'(rows[i][1]) : '0;
			@(negedge VGA_VS);
			if (i > 0) begin // Row i-1 has just finished
				check_val("paddle_0_y", int'(paddle_0_y), rows[i-1][3]);
				check_val("paddle_1_y", int'(paddle_1_y), rows[i-1][4]);
				check_val("score_0", int'(score_0), rows[i-1][5]);
				check_val("score_1", int'(score_1), rows[i-1][6]);
			end
			if (i < NROWS) repeat (rows[i][2]) @(posedge VGA_VS);
		end
		wait_state(ST_IDLE, 20);
		// Random paddle phases over a few rallies
		for (int r = 0; r < 3; r++) begin
			@(posedge VGA_VS);
			joystick_0 <= 8'h10;
			wait_state(ST_PLAY, 20);
			n = 0;
			while (n < 3000) begin
				@(negedge VGA_VS);
				if (!game_running) break;
				@(posedge VGA_VS);
				if (($random(seed) & 3) == 0) begin
					joystick_0 <= 8'($random(seed)) & 8'h0c;
					joystick_1 <= 8'($random(seed)) & 8'h1c; // Fire ignored in play
				end
				n++;
			end
			if (n >= 3000) begin
				timeouts++;
				$display("Timed out at %0t waiting for rally %0d to end", $time, r);
			end
			@(posedge VGA_VS);
			joystick_0 <= '0;
			joystick_1 <= '0;
			wait_state(ST_IDLE, 40);
		end
		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: pong.f
+incdir+.
pong_pkg.sv
field_if.sv
paddle_ctrl.sv
ball_motion.sv
game_fsm.sv
point_timer.sv
pong_core.sv
pong_assert.sv
pong_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build the Pong core testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f pong.f --top-module pong_tb -o pong_sim \
	&& ./obj_dir/pong_sim > sim.log 2>&1 \
	|| echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
